//--- hw/wiscPkg.sv
// WISC core shared definitions
// Opcode and ALU operation encodings, writeback source, and the
// control and commit records passed between the stages

package wiscPkg;

   // Datapath width and register count
   localparam int dataWidth = 16;
   localparam int regCount  = 8;

   //////////////////////////////
   // Instruction opcodes, bits 15 to 11
   //////////////////////////////
   typedef enum logic [4:0] {
      opHalt    = 5'b00000,
      opNop     = 5'b00001,
      opJ       = 5'b00100,
      // Immediate ALU group shares bits 4 to 2
      opAddi    = 5'b01000,
      opSubi    = 5'b01001,
      opXori    = 5'b01010,
      opAndni   = 5'b01011,
      // Branch group, low two bits pick the condition
      opBeqz    = 5'b01100,
      opBnez    = 5'b01101,
      opBltz    = 5'b01110,
      opBgez    = 5'b01111,
      opSt      = 5'b10000,
      opLd      = 5'b10001,
      opSlbi    = 5'b10010,
      opLbi     = 5'b11000,
      opRformat = 5'b11011
   } opcodeT;

   // ALU operations
   // Low four match the low opcode bits and the R-format function
   typedef enum logic [2:0] {
      aluAdd       = 3'b000,
      aluSub       = 3'b001,  // second operand minus first
      aluXor       = 3'b010,
      aluAndn      = 3'b011,  // first AND NOT second
      aluPassB     = 3'b100,
      aluShiftLoad = 3'b101
   } aluOpT;

   // Writeback source
   typedef enum logic {
      wbAlu    = 1'b0,
      wbMemory = 1'b1
   } wbSrcT;

   //////////////////////////////
   // Decoded control for one instruction
   //////////////////////////////
   typedef struct packed {
      aluOpT      aluOp;
      logic       useImm;
      logic       regWrite;
      logic [2:0] destReg;
      logic       memWrite;
      logic       memRead;
      wbSrcT      wbSrc;
      logic       isBranch;
      logic [1:0] brType;
      logic       isJump;
      logic       halt;
   } ctrlT;

   // Record of one retired instruction
   typedef struct packed {
      logic                 valid;
      logic [dataWidth-1:0] pc;
      logic                 regWrite;
      logic [2:0]           regIndex;
      logic [dataWidth-1:0] regData;
      logic                 memWrite;
      logic [dataWidth-1:0] memAddr;
      logic [dataWidth-1:0] memData;
   } commitT;

endpackage

//--- hw/fetchUnit.sv
// Fetch unit
// Program counter and instruction memory preloaded from the program image

`timescale 1ns/1ps

module fetchUnit #(
   parameter int imemAddrWidth = 6
) (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [wiscPkg::dataWidth-1:0]  nextPc,
   input  logic                           stall,
   output logic [wiscPkg::dataWidth-1:0]  instruction,
   output logic [wiscPkg::dataWidth-1:0]  pc
);

   // Word array holding one instruction per entry
   logic [wiscPkg::dataWidth-1:0] imem [2**imemAddrWidth];

   // Low for the first cycle after reset so pc holds at 0
   logic running;

   initial begin
      $readmemh("program.hex", imem);
   end

   //////////////////////////////
   // Combinational fetch
   //////////////////////////////
   // Word index is the byte pc without bit 0
   assign instruction = imem[pc[imemAddrWidth:1]];

   //////////////////////////////
   // Program counter
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         pc      <= '0;
         running <= 1'b0;
      end else begin
         running <= 1'b1;
         // Stall is the halted level and freezes pc for good
         if (running && !stall) begin
            pc <= nextPc;
         end
      end
   end

endmodule

//--- hw/decode.sv
// Decode stage
// Turns the instruction word into the control record, the register
// indices and the extended immediate

`timescale 1ns/1ps

module decode (
   input  logic [wiscPkg::dataWidth-1:0] instruction,
   output wiscPkg::ctrlT                 ctrl,
   output logic [2:0]                    srcA,
   output logic [2:0]                    srcB,
   output logic [wiscPkg::dataWidth-1:0] imm
);

   logic [4:0]                    opBits;
   wiscPkg::opcodeT               opcode;
   logic                          legalOp;
   logic                          zeroExt;
   logic [wiscPkg::dataWidth-1:0] imm5;
   logic [wiscPkg::dataWidth-1:0] imm8;
   logic [wiscPkg::dataWidth-1:0] imm11;

   //////////////////////////////
   // Fields
   //////////////////////////////
   assign opBits = instruction[15:11];
   assign opcode = wiscPkg::opcodeT'(opBits);

   // Rs always from bits 10 to 8
   assign srcA = instruction[10:8];
   // Rt for R-format, store data register for ST
   assign srcB = instruction[7:5];

   assign legalOp = opBits inside {
      wiscPkg::opHalt, wiscPkg::opNop, wiscPkg::opJ,
      wiscPkg::opAddi, wiscPkg::opSubi, wiscPkg::opXori, wiscPkg::opAndni,
      wiscPkg::opBeqz, wiscPkg::opBnez, wiscPkg::opBltz, wiscPkg::opBgez,
      wiscPkg::opSt, wiscPkg::opLd, wiscPkg::opSlbi,
      wiscPkg::opLbi, wiscPkg::opRformat};

   //////////////////////////////
   // Immediate extension
   //////////////////////////////
   // XORI, ANDNI share 0101x; SLBI is the only 8-bit zero extend
   assign zeroExt = (opBits[4:1] == 4'b0101) | (opBits == wiscPkg::opSlbi);

   assign imm5  = zeroExt ? {11'b0, instruction[4:0]}
                          : {{11{instruction[4]}}, instruction[4:0]};
   assign imm8  = zeroExt ? {8'b0, instruction[7:0]}
                          : {{8{instruction[7]}}, instruction[7:0]};
   assign imm11 = {{5{instruction[10]}}, instruction[10:0]};

   //////////////////////////////
   // Control
   //////////////////////////////
   always_comb begin
      // Defaults give a NOP
      ctrl.aluOp    = wiscPkg::aluPassB;
      ctrl.useImm   = 1'b0;
      ctrl.regWrite = 1'b0;
      ctrl.destReg  = instruction[7:5];
      ctrl.memWrite = 1'b0;
      ctrl.memRead  = 1'b0;
      ctrl.wbSrc    = wiscPkg::wbAlu;
      ctrl.isBranch = 1'b0;
      // Branch condition is the low opcode bits
      ctrl.brType   = opBits[1:0];
      ctrl.isJump   = 1'b0;
      ctrl.halt     = 1'b0;
      imm           = imm5;

      case (opcode)
         wiscPkg::opHalt: ctrl.halt = 1'b1;
         wiscPkg::opJ: begin
            ctrl.isJump = 1'b1;
            imm         = imm11;
         end
         // Low opcode bits select the operation directly
         wiscPkg::opAddi, wiscPkg::opSubi, wiscPkg::opXori, wiscPkg::opAndni: begin
            ctrl.aluOp    = wiscPkg::aluOpT'({1'b0, opBits[1:0]});
            ctrl.useImm   = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         wiscPkg::opBeqz, wiscPkg::opBnez, wiscPkg::opBltz, wiscPkg::opBgez: begin
            ctrl.isBranch = 1'b1;
            imm           = imm8;
         end
         wiscPkg::opSt: begin
            ctrl.aluOp    = wiscPkg::aluAdd;
            ctrl.useImm   = 1'b1;
            ctrl.memWrite = 1'b1;
         end
         wiscPkg::opLd: begin
            ctrl.aluOp    = wiscPkg::aluAdd;
            ctrl.useImm   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.memRead  = 1'b1;
            ctrl.wbSrc    = wiscPkg::wbMemory;
         end
         // SLBI and LBI write back into Rs
         wiscPkg::opSlbi, wiscPkg::opLbi: begin
            ctrl.aluOp    = opBits[3] ? wiscPkg::aluPassB : wiscPkg::aluShiftLoad;
            ctrl.useImm   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.destReg  = instruction[10:8];
            imm           = imm8;
         end
         wiscPkg::opRformat: begin
            ctrl.aluOp    = wiscPkg::aluOpT'({1'b0, instruction[1:0]});
            ctrl.regWrite = 1'b1;
            ctrl.destReg  = instruction[4:2];
         end
         default: begin
            // NOP and unknown opcodes keep the defaults
         end
      endcase
   end

   // Every fetched word must carry a known opcode
   assert property (@(instruction) legalOp)
      else $error("Unknown opcode %b", opBits);

endmodule

//--- hw/regFile.sv
// Register file
// Eight 16-bit registers, two combinational reads, one synchronous write

`timescale 1ns/1ps

module regFile (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [2:0]                    srcA,
   input  logic [2:0]                    srcB,
   output logic [wiscPkg::dataWidth-1:0] readA,
   output logic [wiscPkg::dataWidth-1:0] readB,
   input  logic                          writeEnable,
   input  logic [2:0]                    writeIndex,
   input  logic [wiscPkg::dataWidth-1:0] writeData
);

   logic [wiscPkg::dataWidth-1:0] regs [wiscPkg::regCount];

   //////////////////////////////
   // Read ports
   //////////////////////////////
   // No bypass, the write lands at the edge
   assign readA = regs[srcA];
   assign readB = regs[srcB];

   //////////////////////////////
   // Write port
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         // All registers start at zero
         for (int i = 0; i < wiscPkg::regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEnable) begin
         regs[writeIndex] <= writeData;
      end
   end

endmodule

//--- hw/execute.sv
// Execute stage
// ALU plus branch and jump resolution, produces the result and next pc

`timescale 1ns/1ps

module execute (
   input  wiscPkg::ctrlT                 ctrl,
   input  logic [wiscPkg::dataWidth-1:0] pc,
   input  logic [wiscPkg::dataWidth-1:0] readA,
   input  logic [wiscPkg::dataWidth-1:0] readB,
   input  logic [wiscPkg::dataWidth-1:0] imm,
   output logic [wiscPkg::dataWidth-1:0] aluResult,
   output logic [wiscPkg::dataWidth-1:0] storeData,
   output logic [wiscPkg::dataWidth-1:0] nextPc
);

   logic [wiscPkg::dataWidth-1:0] opB;
   logic [wiscPkg::dataWidth-1:0] pcPlus2;
   logic                          condMet;
   logic                          taken;

   //////////////////////////////
   // ALU
   //////////////////////////////
   // Second operand is the immediate or Rt
   assign opB = ctrl.useImm ? imm : readB;

   always_comb begin
      case (ctrl.aluOp)
         wiscPkg::aluAdd:  aluResult = readA + opB;
         // Reversed subtract, immediate or Rt minus Rs
         wiscPkg::aluSub:  aluResult = opB - readA;
         wiscPkg::aluXor:  aluResult = readA ^ opB;
         wiscPkg::aluAndn: aluResult = readA & ~opB;
         // SLBI, Rs shifted up a byte, zero-extended byte below
         wiscPkg::aluShiftLoad: aluResult = {readA[7:0], 8'h00} | opB;
         default:          aluResult = opB;
      endcase
   end

   // ST data comes from the Rd field
   assign storeData = readB;

   //////////////////////////////
   // Branch and jump
   //////////////////////////////
   always_comb begin
      case (ctrl.brType)
         2'b00:   condMet = (readA == '0);
         2'b01:   condMet = (readA != '0);
         // Sign bit decides less than zero
         2'b10:   condMet = readA[wiscPkg::dataWidth-1];
         default: condMet = !readA[wiscPkg::dataWidth-1];
      endcase
   end

   assign taken   = ctrl.isBranch & condMet;
   assign pcPlus2 = pc + 16'd2;

   // Displacement is relative to the following instruction
   assign nextPc = (taken | ctrl.isJump) ? pcPlus2 + imm : pcPlus2;

endmodule

//--- hw/memWriteback.sv
// Memory and writeback
// Data memory, writeback source select, commit record and halt state

`timescale 1ns/1ps

module memWriteback #(
   parameter int dmemAddrWidth = 6
) (
   input  logic                          clk,
   input  logic                          reset,
   input  wiscPkg::ctrlT                 ctrl,
   input  logic [wiscPkg::dataWidth-1:0] pc,
   input  logic [wiscPkg::dataWidth-1:0] aluResult,
   input  logic [wiscPkg::dataWidth-1:0] storeData,
   output logic                          writeEnable,
   output logic [2:0]                    writeIndex,
   output logic [wiscPkg::dataWidth-1:0] writeData,
   output wiscPkg::commitT               commit,
   output logic                          halted
);

   // Idle covers the first cycle after reset
   typedef enum logic [1:0] {
      stIdle,
      stRun,
      stHalted
   } stateT;

   stateT                         state;
   logic                          retire;
   logic [dmemAddrWidth-1:0]      dmemIndex;
   logic [wiscPkg::dataWidth-1:0] loadData;
   logic [wiscPkg::dataWidth-1:0] dmem [2**dmemAddrWidth];

   assign retire = (state == stRun);
   assign halted = (state == stHalted);

   //////////////////////////////
   // Data memory
   //////////////////////////////
   // Word indexed by the byte address without bit 0
   assign dmemIndex = aluResult[dmemAddrWidth:1];
   assign loadData  = dmem[dmemIndex];

   always_ff @(posedge clk) begin
      if (retire && ctrl.memWrite) begin
         dmem[dmemIndex] <= storeData;
      end
   end

   //////////////////////////////
   // Writeback and commit
   //////////////////////////////
   assign writeEnable = retire & ctrl.regWrite;
   assign writeIndex  = ctrl.destReg;
   assign writeData   = (ctrl.wbSrc == wiscPkg::wbMemory) ? loadData : aluResult;

   assign commit.valid    = retire;
   assign commit.pc       = pc;
   assign commit.regWrite = writeEnable;
   assign commit.regIndex = writeIndex;
   assign commit.regData  = writeData;
   assign commit.memWrite = retire & ctrl.memWrite;
   assign commit.memAddr  = aluResult;
   assign commit.memData  = storeData;

   // HALT retires in the run state and then the core stops for good
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= stIdle;
      end else begin
         case (state)
            stIdle:  state <= stRun;
            stRun:   state <= ctrl.halt ? stHalted : stRun;
            default: state <= stHalted;
         endcase
      end
   end

   // Decode never asks for a store and a register write together
   assert property (@(posedge clk) disable iff (reset) !(ctrl.memWrite && ctrl.regWrite))
      else $error("memWrite and regWrite both set at pc %h", pc);

endmodule

//--- hw/wiscCore.sv
// WISC single-cycle core
// Fetch, decode, register file, execute and memory/writeback stages,
// one instruction retired per clock

`timescale 1ns/1ps

module wiscCore #(
   parameter int imemAddrWidth = 6,
   parameter int dmemAddrWidth = 6
) (
   input  logic            clk,
   input  logic            reset,
   output wiscPkg::commitT commit,
   output logic            halted
);

   //////////////////////////////
   // Stage wires
   //////////////////////////////
   logic [wiscPkg::dataWidth-1:0] instruction;
   logic [wiscPkg::dataWidth-1:0] pc;
   logic [wiscPkg::dataWidth-1:0] nextPc;
   wiscPkg::ctrlT                 ctrl;
   logic [2:0]                    srcA;
   logic [2:0]                    srcB;
   logic [wiscPkg::dataWidth-1:0] imm;
   logic [wiscPkg::dataWidth-1:0] readA;
   logic [wiscPkg::dataWidth-1:0] readB;
   logic [wiscPkg::dataWidth-1:0] aluResult;
   logic [wiscPkg::dataWidth-1:0] storeData;
   logic                          writeEnable;
   logic [2:0]                    writeIndex;
   logic [wiscPkg::dataWidth-1:0] writeData;

   // Input side
   fetchUnit #(
      .imemAddrWidth(imemAddrWidth)
   ) fetchUnit_i (
      .clk(clk),
      .reset(reset),
      .nextPc(nextPc),
      .stall(halted),
      .instruction(instruction),
      .pc(pc)
   );

   // Processing
   decode decode_i (
      .instruction(instruction),
      .ctrl(ctrl),
      .srcA(srcA),
      .srcB(srcB),
      .imm(imm)
   );

   regFile regFile_i (
      .clk(clk),
      .reset(reset),
      .srcA(srcA),
      .srcB(srcB),
      .readA(readA),
      .readB(readB),
      .writeEnable(writeEnable),
      .writeIndex(writeIndex),
      .writeData(writeData)
   );

   execute execute_i (
      .ctrl(ctrl),
      .pc(pc),
      .readA(readA),
      .readB(readB),
      .imm(imm),
      .aluResult(aluResult),
      .storeData(storeData),
      .nextPc(nextPc)
   );

   // Output side
   memWriteback #(
      .dmemAddrWidth(dmemAddrWidth)
   ) memWriteback_i (
      .clk(clk),
      .reset(reset),
      .ctrl(ctrl),
      .pc(pc),
      .aluResult(aluResult),
      .storeData(storeData),
      .writeEnable(writeEnable),
      .writeIndex(writeIndex),
      .writeData(writeData),
      .commit(commit),
      .halted(halted)
   );

endmodule

//--- testbench/wiscModel.sv
// WISC instruction-level reference model
// Runs the program image one instruction per DUT retirement and
// presents the commit record that the ISA rules predict

`timescale 1ns/1ps

module wiscModel #(
   parameter int imemAddrWidth = 6,
   parameter int dmemAddrWidth = 6
) (
   input  logic            clk,
   input  logic            reset,
   input  logic            retire,
   output wiscPkg::commitT expected,
   output logic            halted
);

   logic [15:0] imem [2**imemAddrWidth];
   logic [15:0] dmem [2**dmemAddrWidth];
   logic [15:0] regs [8];
   logic [15:0] pc;
   logic [15:0] nextPc;
   logic        haltNow;
   logic [15:0] word;
   logic [4:0]  op;
   logic [15:0] rsVal;
   logic [15:0] rtVal;
   logic [15:0] simm5;
   logic [15:0] zimm5;
   logic [15:0] simm8;
   logic [15:0] zimm8;
   logic [15:0] disp;
   logic [15:0] addr;

   initial begin
      $readmemh("program.hex", imem);
   end

   //////////////////////////////
   // One instruction, ISA rules
   //////////////////////////////
   always_comb begin
      word  = imem[pc[imemAddrWidth:1]];
      op    = word[15:11];
      rsVal = regs[word[10:8]];
      rtVal = regs[word[7:5]];
      simm5 = {{11{word[4]}}, word[4:0]};
      zimm5 = {11'b0, word[4:0]};
      simm8 = {{8{word[7]}}, word[7:0]};
      zimm8 = {8'b0, word[7:0]};
      disp  = {{5{word[10]}}, word[10:0]};
      addr  = rsVal + simm5;
      // Sequential flow unless a branch or jump says otherwise
      nextPc   = pc + 16'd2;
      haltNow  = 1'b0;
      expected = '0;
      expected.valid    = !halted;
      expected.pc       = pc;
      expected.regIndex = word[7:5];
      case (op)
         5'b00000: haltNow = 1'b1;
         5'b00100: nextPc = pc + 16'd2 + disp;
         5'b01000: expected.regData = rsVal + simm5;
         5'b01001: expected.regData = simm5 - rsVal;
         5'b01010: expected.regData = rsVal ^ zimm5;
         5'b01011: expected.regData = rsVal & ~zimm5;
         // Branches test Rs against zero
         5'b01100: if (rsVal == 16'd0) nextPc = pc + 16'd2 + simm8;
         5'b01101: if (rsVal != 16'd0) nextPc = pc + 16'd2 + simm8;
         5'b01110: if ($signed(rsVal) < 0) nextPc = pc + 16'd2 + simm8;
         5'b01111: if ($signed(rsVal) >= 0) nextPc = pc + 16'd2 + simm8;
         5'b10000: begin
            expected.memWrite = 1'b1;
            expected.memAddr  = addr;
            expected.memData  = rtVal;
         end
         5'b10001: expected.regData = dmem[addr[dmemAddrWidth:1]];
         5'b10010: expected.regData = (rsVal << 8) | zimm8;
         5'b11000: expected.regData = simm8;
         5'b11011: begin
            expected.regIndex = word[4:2];
            case (word[1:0])
               2'b00:   expected.regData = rsVal + rtVal;
               2'b01:   expected.regData = rtVal - rsVal;
               2'b10:   expected.regData = rsVal ^ rtVal;
               default: expected.regData = rsVal & ~rtVal;
            endcase
         end
         default: begin
            // NOP
         end
      endcase
      // Register writers, LBI and SLBI target Rs
      expected.regWrite = op inside {5'b01000, 5'b01001, 5'b01010, 5'b01011,
                                     5'b10001, 5'b10010, 5'b11000, 5'b11011};
      if (op inside {5'b10010, 5'b11000}) begin
         expected.regIndex = word[10:8];
      end
   end

   // Architectural state advances only when the DUT retires
   always @(posedge clk) begin
      if (reset) begin
         pc     <= '0;
         halted <= 1'b0;
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (retire && !halted) begin
         pc     <= nextPc;
         halted <= haltNow;
         if (expected.regWrite) begin
            regs[expected.regIndex] <= expected.regData;
         end
         if (expected.memWrite) begin
            dmem[expected.memAddr[dmemAddrWidth:1]] <= expected.memData;
         end
      end
   end

endmodule

//--- testbench/wiscCoreTb.sv
// WISC core testbench
// Runs the program image and checks each commit against the reference model

`timescale 1ns/1ps

module wiscCoreTb;

   localparam int imemAddrWidth = 6;
   localparam int dmemAddrWidth = 6;
   localparam int haltTimeout   = 2000;
   localparam int quietCycles   = 20;

   logic            clk;
   logic            reset;
   wiscPkg::commitT commit;
   logic            halted;
   wiscPkg::commitT expected;
   logic            modelHalted;
   logic            seenCommit;
   int              cycles;

   wiscCore #(
      .imemAddrWidth(imemAddrWidth),
      .dmemAddrWidth(dmemAddrWidth)
   ) wiscCore_i (
      .clk(clk),
      .reset(reset),
      .commit(commit),
      .halted(halted)
   );

   wiscModel #(
      .imemAddrWidth(imemAddrWidth),
      .dmemAddrWidth(dmemAddrWidth)
   ) model (
      .clk(clk),
      .reset(reset),
      .retire(commit.valid),
      .expected(expected),
      .halted(modelHalted)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Marks the first retirement after reset
   always @(posedge clk) begin
      if (reset) begin
         seenCommit <= 1'b0;
      end else if (commit.valid) begin
         seenCommit <= 1'b1;
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////
   // Quiet through reset and the cycle after it
   assert property (@(posedge clk) reset |=> !commit.valid && !halted)
      else begin
         $display("Commit or halted high during reset or the cycle after it at %0t", $time);
         $display("TEST FAILED");
         $fatal(1);
      end

   assert property (@(posedge clk) disable iff (reset)
      commit.valid && !seenCommit |-> commit.pc == 16'h0000)
      else begin
         $display("Mismatch at %0t: first commit.pc dut=%h model=%h",
                  $time, $sampled(commit.pc), 16'h0000);
         $display("TEST FAILED");
         $fatal(1);
      end

   // One retirement per running cycle
   assert property (@(posedge clk) disable iff (reset) !$past(reset) && !halted |-> commit.valid)
      else begin
         $display("Core failed to retire in a running cycle at %0t", $time);
         $display("TEST FAILED");
         $fatal(1);
      end

   // Pc sequence, skipped instructions show up here
   assert property (@(posedge clk) disable iff (reset) commit.valid |-> commit.pc == expected.pc)
      else begin
         $display("Mismatch at %0t: commit.pc dut=%h model=%h",
                  $time, $sampled(commit.pc), $sampled(expected.pc));
         $display("TEST FAILED");
         $fatal(1);
      end

   assert property (@(posedge clk) disable iff (reset)
      commit.valid |-> commit.regWrite == expected.regWrite)
      else begin
         $display("Mismatch at %0t: commit.regWrite dut=%b model=%b",
                  $time, $sampled(commit.regWrite), $sampled(expected.regWrite));
         $display("TEST FAILED");
         $fatal(1);
      end

   assert property (@(posedge clk) disable iff (reset)
      commit.valid && expected.regWrite |-> commit.regIndex == expected.regIndex)
      else begin
         $display("Mismatch at %0t: commit.regIndex dut=%0d model=%0d",
                  $time, $sampled(commit.regIndex), $sampled(expected.regIndex));
         $display("TEST FAILED");
         $fatal(1);
      end

   assert property (@(posedge clk) disable iff (reset)
      commit.valid && expected.regWrite |-> commit.regData == expected.regData)
      else begin
         $display("Mismatch at %0t: commit.regData dut=%h model=%h",
                  $time, $sampled(commit.regData), $sampled(expected.regData));
         $display("TEST FAILED");
         $fatal(1);
      end

   assert property (@(posedge clk) disable iff (reset)
      commit.valid |-> commit.memWrite == expected.memWrite)
      else begin
         $display("Mismatch at %0t: commit.memWrite dut=%b model=%b",
                  $time, $sampled(commit.memWrite), $sampled(expected.memWrite));
         $display("TEST FAILED");
         $fatal(1);
      end

   // Store address and data
   assert property (@(posedge clk) disable iff (reset)
      commit.valid && expected.memWrite |-> commit.memAddr == expected.memAddr)
      else begin
         $display("Mismatch at %0t: commit.memAddr dut=%h model=%h",
                  $time, $sampled(commit.memAddr), $sampled(expected.memAddr));
         $display("TEST FAILED");
         $fatal(1);
      end

   assert property (@(posedge clk) disable iff (reset)
      commit.valid && expected.memWrite |-> commit.memData == expected.memData)
      else begin
         $display("Mismatch at %0t: commit.memData dut=%h model=%h",
                  $time, $sampled(commit.memData), $sampled(expected.memData));
         $display("TEST FAILED");
         $fatal(1);
      end

   // HALT retires once, halted follows it
   assert property (@(posedge clk) disable iff (reset) halted == modelHalted)
      else begin
         $display("Mismatch at %0t: halted dut=%b model=%b",
                  $time, $sampled(halted), $sampled(modelHalted));
         $display("TEST FAILED");
         $fatal(1);
      end

   assert property (@(posedge clk) disable iff (reset) modelHalted |-> !commit.valid)
      else begin
         $display("Core retired an instruction after HALT at %0t", $time);
         $display("TEST FAILED");
         $fatal(1);
      end

   //////////////////////////////
   // Run control
   //////////////////////////////
   initial begin
      reset  = 1'b1;
      cycles = 0;
      // Three rising edges under reset
      repeat (3) @(negedge clk);
      reset = 1'b0;

      while (!halted && cycles < haltTimeout) begin
         @(negedge clk);
         cycles++;
      end

      if (!halted) begin
         $display("Timeout, core did not halt within %0d cycles", haltTimeout);
         $display("TEST FAILED");
         $fatal(1);
      end else begin
         // Quiet period after halt
         repeat (quietCycles) @(negedge clk);
         if (modelHalted) begin
            $display("TEST OK");
            $finish;
         end else begin
            $display("Reference model never reached HALT");
            $display("TEST FAILED");
            $fatal(1);
         end
      end
   end

endmodule

//--- program.hex
// Test program for the WISC core, one 16-bit instruction word per line in hex
// Line n is the word at byte address 2*n, the text after each word names the instruction
c105  // 0x00 LBI   r1, 0x05
c2fd  // 0x02 LBI   r2, -3
91a5  // 0x04 SLBI  r1, 0xa5
417e  // 0x06 ADDI  r3, r1, -2
4a87  // 0x08 SUBI  r4, r2, 7
51bf  // 0x0a XORI  r5, r1, 0x1f
5ad1  // 0x0c ANDNI r6, r2, 0x11
d95c  // 0x0e ADD   r7, r1, r2
d94d  // 0x10 SUB   r3, r1, r2
d9b2  // 0x12 XOR   r4, r1, r5
da9b  // 0x14 ANDN  r6, r2, r4
c010  // 0x16 LBI   r0, 0x10
80e4  // 0x18 ST    r7, r0, 4
88a4  // 0x1a LD    r5, r0, 4
c100  // 0x1c LBI   r1, 0
6002  // 0x1e BEQZ  r0, +2  not taken
6102  // 0x20 BEQZ  r1, +2  taken
c3ee  // 0x22 LBI   r3, 0xee  skipped
6902  // 0x24 BNEZ  r1, +2  not taken
6802  // 0x26 BNEZ  r0, +2  taken
c3ee  // 0x28 LBI   r3, 0xee  skipped
7002  // 0x2a BLTZ  r0, +2  not taken
7202  // 0x2c BLTZ  r2, +2  taken
c3ee  // 0x2e LBI   r3, 0xee  skipped
7a02  // 0x30 BGEZ  r2, +2  not taken
7902  // 0x32 BGEZ  r1, +2  taken
c3ee  // 0x34 LBI   r3, 0xee  skipped
2002  // 0x36 J     +2
c3ee  // 0x38 LBI   r3, 0xee  skipped
0800  // 0x3a NOP
0000  // 0x3c HALT

//--- wiscCore.f
hw/wiscPkg.sv
hw/fetchUnit.sv
hw/decode.sv
hw/regFile.sv
hw/execute.sv
hw/memWriteback.sv
hw/wiscCore.sv
testbench/wiscModel.sv
testbench/wiscCoreTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = wiscCoreTb
FILELIST  = wiscCore.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
